//--- compile.f
logic/video_timing_pkg.sv
logic/gfx_pkg.sv
logic/video_timer.sv
logic/char_layer.sv
logic/scroll_layer.sv
logic/layer_mixer.sv
logic/tilemap_video.sv
tests/tilemap_video_tb.sv

//--- Bender.yml
package:
  name: tilemap_video

sources:
  # Packages first, then the RTL from the leaves up
  - files:
      - logic/video_timing_pkg.sv
      - logic/gfx_pkg.sv
      - logic/video_timer.sv
      - logic/char_layer.sv
      - logic/scroll_layer.sv
      - logic/layer_mixer.sv
      - logic/tilemap_video.sv

  - target: test
    files:
      - tests/tilemap_video_tb.sv

//--- tests/tilemap_video_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tilemap_video_tb;
    import video_timing_pkg::*;
    import gfx_pkg::*;

    localparam int WAIT_LIMIT = 2 * H_TOTAL_DEF * V_TOTAL_DEF;   // Two frames
    localparam int MAP_W      = SCR_COLS * TILE_SIZE;            // Scroll map width in pixels

    logic              clk = 1'b0;
    logic              reset;
    logic              cpu_we;
    logic [CPU_AW-1:0] cpu_addr;
    logic [15:0]       cpu_din;
    logic [ROM_AW-1:0] char_rom_addr;
    logic [ROM_DW-1:0] char_rom_data;
    logic [ROM_AW-1:0] scr_rom_addr;
    logic [ROM_DW-1:0] scr_rom_data;
    logic [1:0]        gfx_en;
    logic [HW-1:0]     h;
    logic [VW-1:0]     v;
    logic              lhbl;
    logic              lvbl;
    logic              hs;
    logic              vs;
    logic              lhbl_dly;
    logic              lvbl_dly;
    logic [7:0]        pxl_color;

    integer            seed;
    logic              check_pix;   // Maps are filled, pixel colors are predictable

    // Shadow state of the reference model
    logic [15:0]       char_shadow [CHAR_COLS * MAP_ROWS];
    logic [15:0]       scr_shadow [SCR_COLS * MAP_ROWS];
    logic [8:0]        scroll_pend;
    logic [8:0]        scroll_act;
    logic [2:0][7:0]   p_char;      // Predictions moving down the pipeline
    logic [2:0][7:0]   p_scr;
    logic [1:0][ROM_AW-1:0] p_caddr;   // ROM addresses, two cycles behind the beam
    logic [1:0][ROM_AW-1:0] p_saddr;
    logic [2:0]        p_hb;
    logic [2:0]        p_vb;
    logic [7:0]        exp_color;
    logic              exp_lhbl;
    logic              exp_lvbl;
    logic [HW-1:0]     exp_h;
    logic [VW-1:0]     exp_v;
    int                run_cycles;

    always #4 clk = ~clk;

    tilemap_video tilemap_video_inst (
        .clk           ( clk           ),
        .reset         ( reset         ),
        .cpu_we        ( cpu_we        ),
        .cpu_addr      ( cpu_addr      ),
        .cpu_din       ( cpu_din       ),
        .char_rom_addr ( char_rom_addr ),
        .char_rom_data ( char_rom_data ),
        .scr_rom_addr  ( scr_rom_addr  ),
        .scr_rom_data  ( scr_rom_data  ),
        .gfx_en        ( gfx_en        ),
        .h             ( h             ),
        .v             ( v             ),
        .lhbl          ( lhbl          ),
        .lvbl          ( lvbl          ),
        .hs            ( hs            ),
        .vs            ( vs            ),
        .lhbl_dly      ( lhbl_dly      ),
        .lvbl_dly      ( lvbl_dly      ),
        .pxl_color     ( pxl_color     )
    );

    function automatic logic [3:0] char_nibble(input logic [ROM_AW-1:0] addr, input int n);
        return addr[3:0] + 4'(n);   // (address + nibble) mod 16
    endfunction

    function automatic logic [3:0] scroll_nibble(input logic [ROM_AW-1:0] addr, input int n);
        logic [3:0] mixed;
        mixed = addr[3:0] ^ addr[7:4] ^ addr[11:8] ^ {1'b0, addr[14:12]};
        return mixed + 4'(5 * n);
    endfunction

    function automatic logic [ROM_DW-1:0] rom_row(input logic [ROM_AW-1:0] addr, input bit scr);
        logic [ROM_DW-1:0] row;
        for (int n = 0; n < 8; n++) begin
            row[4*n +: 4] = scr ? scroll_nibble(addr, n) : char_nibble(addr, n);
        end
        return row;
    endfunction

    // ROMs with one cycle of read latency
    always @(posedge clk) begin
        char_rom_data <= rom_row(char_rom_addr, 1'b0);
        scr_rom_data  <= rom_row(scr_rom_addr, 1'b1);
    end

    function automatic logic [ROM_AW-1:0] char_fetch_addr(input int x, input int y);
        logic [15:0] entry;
        entry = char_shadow[(y / TILE_SIZE) * CHAR_COLS + x / TILE_SIZE];
        return {entry[11:0], 3'(y % TILE_SIZE)};
    endfunction

    function automatic logic [ROM_AW-1:0] scroll_fetch_addr(input int x, input int y,
                                                            input logic [8:0] pos);
        logic [15:0] entry;
        int          sx;
        sx    = (x + int'(pos)) % MAP_W;   // Scroll map wraps
        entry = scr_shadow[(y / TILE_SIZE) * SCR_COLS + sx / TILE_SIZE];
        return {entry[11:0], 3'(y % TILE_SIZE)};
    endfunction

    function automatic logic [7:0] predict_char(input int x, input int y);
        logic [15:0] entry;
        entry = char_shadow[(y / TILE_SIZE) * CHAR_COLS + x / TILE_SIZE];
        return {entry[15:12], char_nibble(char_fetch_addr(x, y), x % TILE_SIZE)};
    endfunction

    function automatic logic [7:0] predict_scroll(input int x, input int y, input logic [8:0] pos);
        logic [15:0] entry;
        int          sx;
        sx    = (x + int'(pos)) % MAP_W;
        entry = scr_shadow[(y / TILE_SIZE) * SCR_COLS + sx / TILE_SIZE];
        return {entry[15:12], scroll_nibble(scroll_fetch_addr(x, y, pos), sx % TILE_SIZE)};
    endfunction

    function automatic logic [7:0] mix_color(input logic vis, input logic [7:0] chr,
                                             input logic [7:0] scr, input logic [1:0] en);
        if (!vis) return 8'h00;
        if (en[0] && (chr[3:0] != PIX_TRANSPARENT)) return chr;
        if (en[1]) return scr;
        return 8'h00;
    endfunction

    function automatic bit in_window(input int val, input int start, input int len);
        return (val >= start) && (val < start + len);
    endfunction

    // Reference model, one prediction per beam position
    always @(posedge clk) begin : ref_model
        int x;
        int y;
        bit vis;
        if (reset) begin
            scroll_pend = '0;
            scroll_act  = '0;
            p_char     <= '0;
            p_scr      <= '0;
            p_caddr    <= '0;
            p_saddr    <= '0;
            p_hb       <= '0;
            p_vb       <= '0;
            exp_color  <= '0;
            exp_lhbl   <= 1'b0;
            exp_lvbl   <= 1'b0;
            exp_h      <= '0;
            exp_v      <= '0;
            run_cycles <= 0;
        end else begin
            x   = int'(h);
            y   = int'(v);
            vis = (x < H_ACTIVE) && (y < V_ACTIVE);
            if (x == 0 && y == 0) begin
                scroll_act = scroll_pend;   // Frame start takes the pending offset
            end
            p_char  <= {p_char[1:0], vis ? predict_char(x, y) : 8'h00};
            p_scr   <= {p_scr[1:0], vis ? predict_scroll(x, y, scroll_act) : 8'h00};
            p_caddr <= {p_caddr[0], vis ? char_fetch_addr(x, y) : ROM_AW'(0)};
            p_saddr <= {p_saddr[0], vis ? scroll_fetch_addr(x, y, scroll_act) : ROM_AW'(0)};
            p_hb    <= {p_hb[1:0], x < H_ACTIVE};
            p_vb    <= {p_vb[1:0], y < V_ACTIVE};
            exp_color <= mix_color(p_hb[2] && p_vb[2], p_char[2], p_scr[2], gfx_en);
            exp_lhbl  <= p_hb[2];
            exp_lvbl  <= p_vb[2];
            exp_h     <= (x == H_TOTAL_DEF - 1) ? '0 : h + 1'b1;
            if (x == H_TOTAL_DEF - 1) begin
                exp_v <= (y == V_TOTAL_DEF - 1) ? '0 : v + 1'b1;
            end else begin
                exp_v <= v;
            end
            run_cycles <= run_cycles + 1;
            if (cpu_we) begin
                if (cpu_addr < 6'h08) begin
                    char_shadow[cpu_addr[2:0]] = cpu_din;
                end else if (cpu_addr >= 6'h10 && cpu_addr < 6'h20) begin
                    scr_shadow[cpu_addr - 6'h10] = cpu_din;
                end else if (cpu_addr == 6'h20) begin
                    scroll_pend = cpu_din[8:0];
                end
            end
        end
    end

    task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("FAIL %s expected %h got %h", name, expected, actual);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic flag_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    reset_state: assert property (@(posedge clk) reset |=> (h == '0 && v == '0 && !hs && !vs))
        else flag_mismatch("{h,v,hs,vs}", 0, $sampled({h, v, hs, vs}));
    h_steps: assert property (@(posedge clk) disable iff (reset) run_cycles >= 1 |-> h == exp_h)
        else flag_mismatch("h", $sampled(exp_h), $sampled(h));
    v_steps: assert property (@(posedge clk) disable iff (reset) run_cycles >= 1 |-> v == exp_v)
        else flag_mismatch("v", $sampled(exp_v), $sampled(v));
    lhbl_window: assert property (@(posedge clk) disable iff (reset) lhbl == (h < H_ACTIVE))
        else flag_mismatch("lhbl", $sampled(h) < H_ACTIVE, $sampled(lhbl));
    lvbl_window: assert property (@(posedge clk) disable iff (reset) lvbl == (v < V_ACTIVE))
        else flag_mismatch("lvbl", $sampled(v) < V_ACTIVE, $sampled(lvbl));
    hs_window: assert property (@(posedge clk) disable iff (reset)
        hs == in_window(h, HS_START_DEF, HS_LEN_DEF))
        else flag_mismatch("hs", in_window($sampled(h), HS_START_DEF, HS_LEN_DEF), $sampled(hs));
    vs_window: assert property (@(posedge clk) disable iff (reset)
        vs == in_window(v, VS_START_DEF, VS_LEN_DEF))
        else flag_mismatch("vs", in_window($sampled(v), VS_START_DEF, VS_LEN_DEF), $sampled(vs));
    lhbl_delay: assert property (@(posedge clk) disable iff (reset) lhbl_dly == exp_lhbl)
        else flag_mismatch("lhbl_dly", $sampled(exp_lhbl), $sampled(lhbl_dly));
    lvbl_delay: assert property (@(posedge clk) disable iff (reset) lvbl_dly == exp_lvbl)
        else flag_mismatch("lvbl_dly", $sampled(exp_lvbl), $sampled(lvbl_dly));
    char_rom_fetch: assert property (@(posedge clk) disable iff (reset)
        check_pix && p_hb[1] && p_vb[1] |-> char_rom_addr == p_caddr[1])
        else flag_mismatch("char_rom_addr", $sampled(p_caddr[1]), $sampled(char_rom_addr));
    scr_rom_fetch: assert property (@(posedge clk) disable iff (reset)
        check_pix && p_hb[1] && p_vb[1] |-> scr_rom_addr == p_saddr[1])
        else flag_mismatch("scr_rom_addr", $sampled(p_saddr[1]), $sampled(scr_rom_addr));
    pixel_color: assert property (@(posedge clk) disable iff (reset)
        check_pix |-> pxl_color == exp_color)
        else flag_mismatch("pxl_color", $sampled(exp_color), $sampled(pxl_color));
    blank_black: assert property (@(posedge clk) disable iff (reset)
        !(lhbl_dly && lvbl_dly) |-> pxl_color == 8'h00)
        else flag_mismatch("pxl_color in blank", 0, $sampled(pxl_color));

    // One-cycle write strobe, called right after a rising edge
    task automatic cpu_write(input logic [CPU_AW-1:0] addr, input logic [15:0] data);
        cpu_we   <= 1'b1;
        cpu_addr <= addr;
        cpu_din  <= data;
        @(posedge clk);
        cpu_we   <= 1'b0;
    endtask

    task automatic fill_maps();
        for (int i = 0; i < CHAR_COLS * MAP_ROWS; i++) begin
            cpu_write(CHAR_BASE + 6'(i), 16'($random(seed)));
        end
        for (int i = 0; i < SCR_COLS * MAP_ROWS; i++) begin
            cpu_write(SCR_BASE + 6'(i), 16'($random(seed)));
        end
    endtask

    task automatic wait_for_vblank();
        int n;
        n = 0;
        while (lvbl && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (lvbl) flag_timeout("vertical blank");
    endtask

    task automatic wait_for_frame_start();
        int n;
        n = 0;
        while (!(h == '0 && v == '0) && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!(h == '0 && v == '0)) flag_timeout("frame start");
    endtask

    task automatic wait_for_line(input int line);
        int n;
        n = 0;
        while (int'(v) != line && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (int'(v) != line) flag_timeout("video line");
    endtask

    initial begin
        seed          = 32'hf98ef202;
        reset         = 1'b1;
        cpu_we        = 1'b0;
        cpu_addr      = '0;
        cpu_din       = '0;
        gfx_en        = 2'b00;
        char_rom_data = '0;
        scr_rom_data  = '0;
        check_pix     = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // Frame 0 shows unwritten maps
        wait_for_vblank();
        fill_maps();
        cpu_write(SCROLL_ADDR, 16'h01f5);     // Offset 53 after the mod 64
        gfx_en    <= 2'b01;
        check_pix <= 1'b1;

        wait_for_frame_start();               // Characters only
        wait_for_vblank();
        gfx_en <= 2'b10;

        wait_for_frame_start();               // Scroll only, wraps past column 63
        wait_for_line(4);
        cpu_write(SCROLL_ADDR, 16'hfe3c);     // Mid-frame write, offset 60
        wait_for_vblank();
        fill_maps();
        gfx_en <= 2'b11;

        wait_for_frame_start();               // Both layers with the new offset
        wait_for_vblank();
        gfx_en <= 2'b00;
        wait_for_frame_start();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/tilemap_video.sv
`timescale 1ns/1ps
`default_nettype none

module tilemap_video #(
    parameter int H_TOTAL  = video_timing_pkg::H_TOTAL_DEF,
    parameter int V_TOTAL  = video_timing_pkg::V_TOTAL_DEF,
    parameter int HS_START = video_timing_pkg::HS_START_DEF,
    parameter int HS_LEN   = video_timing_pkg::HS_LEN_DEF,
    parameter int VS_START = video_timing_pkg::VS_START_DEF,
    parameter int VS_LEN   = video_timing_pkg::VS_LEN_DEF
) (
    input  logic                            clk,
    input  logic                            reset,
    // CPU write port
    input  logic                            cpu_we,
    input  logic [gfx_pkg::CPU_AW-1:0]      cpu_addr,
    input  gfx_pkg::cpu_word_t              cpu_din,
    // Graphics ROMs
    output logic [gfx_pkg::ROM_AW-1:0]      char_rom_addr,
    input  logic [gfx_pkg::ROM_DW-1:0]      char_rom_data,
    output logic [gfx_pkg::ROM_AW-1:0]      scr_rom_addr,
    input  logic [gfx_pkg::ROM_DW-1:0]      scr_rom_data,
    input  logic [1:0]                      gfx_en,     // Bit 0 char, bit 1 scroll
    // Video out
    output logic [video_timing_pkg::HW-1:0] h,
    output logic [video_timing_pkg::VW-1:0] v,
    output logic                            lhbl,
    output logic                            lvbl,
    output logic                            hs,
    output logic                            vs,
    output logic                            lhbl_dly,
    output logic                            lvbl_dly,
    output logic [7:0]                      pxl_color
);

    logic [3:0] char_pix;
    logic [3:0] char_pal;
    logic [3:0] scr_pix;
    logic [3:0] scr_pal;

    video_timer #(
        .H_TOTAL  ( H_TOTAL  ),
        .V_TOTAL  ( V_TOTAL  ),
        .HS_START ( HS_START ),
        .HS_LEN   ( HS_LEN   ),
        .VS_START ( VS_START ),
        .VS_LEN   ( VS_LEN   )
    ) u_timer (
        .clk   ( clk   ),
        .reset ( reset ),
        .h     ( h     ),
        .v     ( v     ),
        .lhbl  ( lhbl  ),
        .lvbl  ( lvbl  ),
        .hs    ( hs    ),
        .vs    ( vs    )
    );

    char_layer u_char (
        .clk      ( clk           ),
        .reset    ( reset         ),
        .h        ( h             ),
        .v        ( v             ),
        .cpu_we   ( cpu_we        ),
        .cpu_addr ( cpu_addr      ),
        .cpu_din  ( cpu_din       ),
        .rom_addr ( char_rom_addr ),
        .rom_data ( char_rom_data ),
        .char_pix ( char_pix      ),
        .char_pal ( char_pal      )
    );

    scroll_layer u_scroll (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .h            ( h            ),
        .v            ( v            ),
        .cpu_we       ( cpu_we       ),
        .cpu_addr     ( cpu_addr     ),
        .cpu_din      ( cpu_din      ),
        .scr_rom_addr ( scr_rom_addr ),
        .scr_rom_data ( scr_rom_data ),
        .scr_pix      ( scr_pix      ),
        .scr_pal      ( scr_pal      )
    );

    layer_mixer u_mixer (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .char_pix  ( char_pix  ),
        .char_pal  ( char_pal  ),
        .scr_pix   ( scr_pix   ),
        .scr_pal   ( scr_pal   ),
        .gfx_en    ( gfx_en    ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  ),
        .pxl_color ( pxl_color )
    );

endmodule

`default_nettype wire

//--- logic/layer_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module layer_mixer (
    input  logic       clk,
    input  logic       reset,
    input  logic       lhbl,
    input  logic       lvbl,
    input  logic [3:0] char_pix,
    input  logic [3:0] char_pal,
    input  logic [3:0] scr_pix,
    input  logic [3:0] scr_pal,
    input  logic [1:0] gfx_en,
    output logic       lhbl_dly,
    output logic       lvbl_dly,
    output logic [7:0] pxl_color
);
    import gfx_pkg::*;

    // Three stages to meet the layer pixels
    logic [2:0] lhbl_sr;
    logic [2:0] lvbl_sr;
    logic       visible;

    assign visible = lhbl_sr[2] && lvbl_sr[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            lhbl_sr   <= '0;
            lvbl_sr   <= '0;
            lhbl_dly  <= 1'b0;
            lvbl_dly  <= 1'b0;
            pxl_color <= '0;
        end else begin
            lhbl_sr  <= {lhbl_sr[1:0], lhbl};
            lvbl_sr  <= {lvbl_sr[1:0], lvbl};
            lhbl_dly <= lhbl_sr[2];
            lvbl_dly <= lvbl_sr[2];
            if (!visible) begin
                pxl_color <= '0;
            end else if (gfx_en[0] && (char_pix != PIX_TRANSPARENT)) begin
                pxl_color <= {char_pal, char_pix};      // Characters on top
            end else if (gfx_en[1]) begin
                pxl_color <= {scr_pal, scr_pix};
            end else begin
                pxl_color <= '0;
            end
        end
    end

    // No color leaks into blanking, four pixels behind the beam
    blank_is_black: assert property (@(posedge clk) disable iff (reset)
        !($past(lhbl, 4) && $past(lvbl, 4)) |-> (pxl_color == '0));

endmodule

`default_nettype wire

//--- logic/scroll_layer.sv
`timescale 1ns/1ps
`default_nettype none

module scroll_layer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [video_timing_pkg::HW-1:0] h,
    input  logic [video_timing_pkg::VW-1:0] v,
    input  logic                            cpu_we,
    input  logic [gfx_pkg::CPU_AW-1:0]      cpu_addr,
    input  gfx_pkg::cpu_word_t              cpu_din,
    output logic [gfx_pkg::ROM_AW-1:0]      scr_rom_addr,
    input  logic [gfx_pkg::ROM_DW-1:0]      scr_rom_data,
    output logic [3:0]                      scr_pix,
    output logic [3:0]                      scr_pal
);
    import gfx_pkg::*;

    localparam int TB    = $clog2(TILE_SIZE);
    localparam int RW    = $clog2(MAP_ROWS);
    localparam int MAP_N = SCR_COLS * MAP_ROWS;
    localparam int IW    = $clog2(MAP_N);
    localparam int XW    = $clog2(SCR_COLS * TILE_SIZE);  // Map width in pixels

    cpu_word_t scr_map [MAP_N];

    logic          scr_wr;
    logic          scroll_wr;
    logic [IW-1:0] wr_idx;
    logic [IW-1:0] rd_idx;
    logic          frame_start;

    logic [8:0]    scroll_pend;
    logic [8:0]    scroll_act;
    logic [8:0]    scroll_now;
    logic [XW-1:0] eff_x;

    cpu_word_t     s1_entry;
    logic [TB-1:0] s1_row;
    logic [TB-1:0] s1_px;
    logic [TB-1:0] s2_px;
    logic [3:0]    s2_pal;
    logic [TB-1:0] s3_px;
    logic [3:0]    s3_pal;

    assign scr_wr      = cpu_we && (cpu_addr[CPU_AW-1:IW] == SCR_BASE[CPU_AW-1:IW]);
    assign scroll_wr   = cpu_we && (cpu_addr == SCROLL_ADDR);
    assign wr_idx      = cpu_addr[IW-1:0];
    assign frame_start = (h == '0) && (v == '0);

    // The first pixel of a frame already sees the new position
    assign scroll_now = frame_start ? scroll_pend : scroll_act;
    assign eff_x      = h[XW-1:0] + scroll_now[XW-1:0];  // Wraps at 64
    assign rd_idx     = {v[TB +: RW], eff_x[XW-1:TB]};

    always_ff @(posedge clk) begin
        if (scr_wr) begin
            scr_map[wr_idx] <= cpu_din;
        end
    end

    // Scroll position, pending until frame start
    always_ff @(posedge clk) begin
        if (reset) begin
            scroll_pend <= '0;
            scroll_act  <= '0;
        end else begin
            if (scroll_wr) begin
                scroll_pend <= cpu_din.scroll.hpos;
            end
            if (frame_start) begin
                scroll_act <= scroll_pend;
            end
        end
    end

    // Stage 1, map lookup at the scrolled column
    always_ff @(posedge clk) begin
        s1_entry <= scr_map[rd_idx];
        s1_row   <= v[TB-1:0];
        s1_px    <= eff_x[TB-1:0];
    end

    // Stage 2
    always_ff @(posedge clk) begin
        scr_rom_addr <= {s1_entry.tile.code, s1_row};
        s2_px        <= s1_px;
        s2_pal       <= s1_entry.tile.pal;
    end

    // Stage 3
    always_ff @(posedge clk) begin
        s3_px  <= s2_px;
        s3_pal <= s2_pal;
    end

    assign scr_pix = scr_rom_data[{s3_px, 2'b00} +: 4];
    assign scr_pal = s3_pal;

    // Active offset moves only on a frame boundary
    scroll_frame_latch: assert property (@(posedge clk) disable iff (reset)
        !$stable(scroll_act) |-> $past(frame_start));

endmodule

`default_nettype wire

//--- logic/char_layer.sv
`timescale 1ns/1ps
`default_nettype none

module char_layer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [video_timing_pkg::HW-1:0] h,
    input  logic [video_timing_pkg::VW-1:0] v,
    input  logic                            cpu_we,
    input  logic [gfx_pkg::CPU_AW-1:0]      cpu_addr,
    input  gfx_pkg::cpu_word_t              cpu_din,
    output logic [gfx_pkg::ROM_AW-1:0]      rom_addr,
    input  logic [gfx_pkg::ROM_DW-1:0]      rom_data,
    output logic [3:0]                      char_pix,
    output logic [3:0]                      char_pal
);
    import gfx_pkg::*;

    localparam int TB    = $clog2(TILE_SIZE);   // Pixel bits within a tile
    localparam int CW    = $clog2(CHAR_COLS);
    localparam int RW    = $clog2(MAP_ROWS);
    localparam int MAP_N = CHAR_COLS * MAP_ROWS;
    localparam int IW    = $clog2(MAP_N);

    cpu_word_t char_map [MAP_N];

    logic          char_wr;
    logic [IW-1:0] wr_idx;
    logic [IW-1:0] rd_idx;

    // Pipeline registers
    cpu_word_t     s1_entry;
    logic [TB-1:0] s1_row;
    logic [TB-1:0] s1_px;
    logic [TB-1:0] s2_px;
    logic [3:0]    s2_pal;
    logic [TB-1:0] s3_px;
    logic [3:0]    s3_pal;

    // Claim 0x00-0x07 only
    assign char_wr = cpu_we && (cpu_addr[CPU_AW-1:IW] == CHAR_BASE[CPU_AW-1:IW]);
    assign wr_idx  = cpu_addr[IW-1:0];
    assign rd_idx  = {v[TB +: RW], h[TB +: CW]};    // Row major, 4 tiles per row

    always_ff @(posedge clk) begin
        if (char_wr) begin
            char_map[wr_idx] <= cpu_din;
        end
    end

    // Stage 1, map lookup
    always_ff @(posedge clk) begin
        s1_entry <= char_map[rd_idx];
        s1_row   <= v[TB-1:0];
        s1_px    <= h[TB-1:0];
    end

    // Stage 2, ROM address out
    always_ff @(posedge clk) begin
        rom_addr <= {s1_entry.tile.code, s1_row};
        s2_px    <= s1_px;
        s2_pal   <= s1_entry.tile.pal;
    end

    // Stage 3 lines up with the ROM data
    always_ff @(posedge clk) begin
        s3_px  <= s2_px;
        s3_pal <= s2_pal;
    end

    assign char_pix = rom_data[{s3_px, 2'b00} +: 4];   // Nibble x is pixel x
    assign char_pal = s3_pal;

    // Writes below the scroll map land inside the character map
    char_wr_in_map: assert property (@(posedge clk) disable iff (reset)
        (cpu_we && (cpu_addr < SCR_BASE)) |-> ((cpu_addr - CHAR_BASE) < CPU_AW'(MAP_N)));

endmodule

`default_nettype wire

//--- logic/video_timer.sv
`timescale 1ns/1ps
`default_nettype none

module video_timer #(
    parameter int H_TOTAL  = video_timing_pkg::H_TOTAL_DEF,
    parameter int V_TOTAL  = video_timing_pkg::V_TOTAL_DEF,
    parameter int HS_START = video_timing_pkg::HS_START_DEF,
    parameter int HS_LEN   = video_timing_pkg::HS_LEN_DEF,
    parameter int VS_START = video_timing_pkg::VS_START_DEF,
    parameter int VS_LEN   = video_timing_pkg::VS_LEN_DEF
) (
    input  logic                            clk,
    input  logic                            reset,
    output logic [video_timing_pkg::HW-1:0] h,
    output logic [video_timing_pkg::VW-1:0] v,
    output logic                            lhbl,
    output logic                            lvbl,
    output logic                            hs,
    output logic                            vs
);
    import video_timing_pkg::*;
    import gfx_pkg::*;

    logic [HW-1:0] h_nxt;
    logic [VW-1:0] v_nxt;

    // Next beam position
    always_comb begin
        h_nxt = h + 1'b1;
        v_nxt = v;
        if (h == HW'(H_TOTAL - 1)) begin
            h_nxt = '0;
            v_nxt = (v == VW'(V_TOTAL - 1)) ? '0 : v + 1'b1;
        end
    end

    // Blanking and sync are built from the next count so they line up with h and v
    always_ff @(posedge clk) begin
        if (reset) begin
            h    <= '0;
            v    <= '0;
            lhbl <= 1'b1;   // h = 0 is visible
            lvbl <= 1'b1;
            hs   <= 1'b0;
            vs   <= 1'b0;
        end else begin
            h    <= h_nxt;
            v    <= v_nxt;
            lhbl <= h_nxt < HW'(H_ACTIVE);
            lvbl <= v_nxt < VW'(V_ACTIVE);
            hs   <= (h_nxt >= HW'(HS_START)) && (h_nxt < HW'(HS_START + HS_LEN));
            vs   <= (v_nxt >= VW'(VS_START)) && (v_nxt < VW'(VS_START + VS_LEN));
        end
    end

    // Beam never leaves the frame
    beam_in_frame: assert property (@(posedge clk) disable iff (reset)
        (h < HW'(H_TOTAL)) && (v < VW'(V_TOTAL)));

endmodule

`default_nettype wire

//--- logic/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

    localparam int H_ACTIVE  = 32;  // Visible pixels, maps sized to this
    localparam int V_ACTIVE  = 16;
    localparam int TILE_SIZE = 8;
    localparam int CHAR_COLS = 4;
    localparam int SCR_COLS  = 8;   // Twice the screen width, wraps
    localparam int MAP_ROWS  = 2;

    // One ROM word is a pattern row of 8 nibbles, pixel 0 in the low bits
    localparam int ROM_AW = 15;
    localparam int ROM_DW = 32;

    // CPU address map
    localparam int CPU_AW = 6;
    localparam logic [CPU_AW-1:0] CHAR_BASE   = 6'h00;
    localparam logic [CPU_AW-1:0] SCR_BASE    = 6'h10;
    localparam logic [CPU_AW-1:0] SCROLL_ADDR = 6'h20;

    localparam logic [3:0] PIX_TRANSPARENT = 4'd0;

    // CPU data word, either a tile map entry or a scroll position
    typedef union packed {
        struct packed {
            logic [3:0]  pal;
            logic [11:0] code;
        } tile;
        struct packed {
            logic [6:0] unused;
            logic [8:0] hpos;
        } scroll;
    } cpu_word_t;

endpackage

`default_nettype wire

//--- logic/video_timing_pkg.sv
`default_nettype none

package video_timing_pkg;

    // Beam timing defaults, in pixels and lines
    localparam int H_TOTAL_DEF  = 48;   // Pixels per line
    localparam int V_TOTAL_DEF  = 24;   // Lines per frame

    // Horizontal sync window
    localparam int HS_START_DEF = 36;
    localparam int HS_LEN_DEF   = 4;

    // Vertical sync window
    localparam int VS_START_DEF = 18;
    localparam int VS_LEN_DEF   = 2;

    // Beam counter widths
    localparam int HW = 6;
    localparam int VW = 6;

endpackage

`default_nettype wire
